// ==== src/usbBufPkg.sv ====
// USB receive buffer definitions

package usbBufPkg;

	// ring geometry, four entries per word
	localparam int ENTRY_W = 9;
	localparam int LANES = 4;
	localparam int WORD_W = ENTRY_W * LANES;
	localparam int INDEX_W = 10;
	localparam int WORD_ADDR_W = 8;
	localparam int RING_WORDS = 1 << WORD_ADDR_W;
	localparam logic [ENTRY_W-1:0] EOP_ENTRY = 9'h100;

	// full-speed bit timing in system clocks
	localparam int BIT_CYCLES = 8;
	localparam int PHASE_W = $clog2(BIT_CYCLES);
	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(BIT_CYCLES - 1);
	localparam logic [PHASE_W-1:0] PHASE_STROBE = PHASE_W'(BIT_CYCLES / 2 - 1);

	// line states as {D-, D+}
	localparam logic [1:0] LINE_SE0 = 2'b00;
	localparam logic [1:0] LINE_J = 2'b01;

	// receive framing
	localparam logic [7:0] SYNC_PATTERN = 8'b1000_0000;
	localparam logic [2:0] STUFF_RUN = 3'd6;

	// MMIO bus
	localparam int MMIO_DATA_W = 64;
	localparam int MMIO_ADDR_W = 32;
	localparam int MMIO_OPM_W = 5;
	localparam int FIELD_W = 16;

	typedef enum logic [1:0] {
		OK_READY = 2'd0,
		OK_OK = 2'd1,
		OK_HOLD = 2'd2
	} mmioOkT;

	localparam logic [1:0] OPM_READ = 2'd1;
	localparam logic [1:0] OPM_WRITE = 2'd2;

	// address windows and control registers
	localparam logic [2:0] BUF_SEL = 3'd4;
	localparam logic [7:0] CTL_SEL = 8'hE8;
	localparam logic [5:0] REG_RX_START = 6'd0;
	localparam logic [5:0] REG_RX_END = 6'd1;
	localparam logic [5:0] REG_STATUS = 6'd2;

endpackage

// ==== src/usbLineSampler.sv ====
// USB line sampler

`timescale 1ns/1ns

module usbLineSampler (
	input logic clock,
	input logic reset,
	input logic dPlus,
	input logic dMinus,
	output logic [1:0] lineState,
	output logic bitStrobe
);
	import usbBufPkg::*;

	logic [1:0] syncMeta;
	logic [1:0] prevLine;
	logic [PHASE_W-1:0] phase;
	logic lineChange;

	// any edge on the pair realigns the bit clock
	assign lineChange = (lineState != prevLine);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			syncMeta <= LINE_SE0;
			lineState <= LINE_SE0;
			prevLine <= LINE_SE0;
			phase <= '0;
			bitStrobe <= 1'b0;
		end
		else
		begin
			// two-flop synchroniser
			syncMeta <= {dMinus, dPlus};
			lineState <= syncMeta;
			prevLine <= lineState;

			if (lineChange)
				phase <= PHASE_W'(1);
			else if (phase == PHASE_LAST)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			// strobe lands at mid-bit, half a bit after the edge
			bitStrobe <= !lineChange && (phase == PHASE_STROBE);
		end
	end

endmodule

// ==== src/usbRxDecoder.sv ====
// USB receive bit decoder

`timescale 1ns/1ns

module usbRxDecoder (
	input logic clock,
	input logic reset,
	input logic [1:0] lineState,
	input logic bitStrobe,
	output logic entryValid,
	output logic [usbBufPkg::ENTRY_W-1:0] entry,
	output logic packetActive
);
	import usbBufPkg::*;

	logic [1:0] prevState;
	logic [7:0] bitWindow;
	logic [2:0] onesCount;
	logic [2:0] bitCount;
	logic decodedBit;
	logic [7:0] nextWindow;
	logic lineSe0;
	logic lineData;

	assign lineSe0 = (lineState == LINE_SE0);
	// J or K, SE1 is ignored
	assign lineData = lineState[1] ^ lineState[0];

	// NRZI: no change is a one
	assign decodedBit = (lineState == prevState);

	// LSB first, so new bits enter at the top
	assign nextWindow = {decodedBit, bitWindow[7:1]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			prevState <= LINE_J;
			bitWindow <= '1;
			onesCount <= '0;
			bitCount <= '0;
			packetActive <= 1'b0;
			entryValid <= 1'b0;
		end
		else
		begin
			entryValid <= 1'b0;
			if (bitStrobe)
			begin
				if (lineSe0)
				begin
					// end of packet, a partial byte is dropped
					if (packetActive)
						entryValid <= 1'b1;
					packetActive <= 1'b0;
					prevState <= lineState;
					bitWindow <= '1;
					onesCount <= '0;
					bitCount <= '0;
				end
				else if (lineData)
				begin
					prevState <= lineState;
					if (!packetActive)
					begin
						bitWindow <= nextWindow;
						if (nextWindow == SYNC_PATTERN)
						begin
							packetActive <= 1'b1;
							// trailing one of the sync counts toward stuffing
							onesCount <= 3'd1;
							bitCount <= '0;
						end
					end
					else if (onesCount == STUFF_RUN)
					begin
						// stuffed bit, discard
						onesCount <= '0;
					end
					else
					begin
						bitWindow <= nextWindow;
						onesCount <= decodedBit ? onesCount + 3'd1 : 3'd0;
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7)
							entryValid <= 1'b1;
					end
				end
			end
		end
	end

	// entry payload, only meaningful while entryValid is high
	always_ff @(posedge clock)
	begin
		if (bitStrobe)
			entry <= lineSe0 ? EOP_ENTRY : {1'b0, nextWindow};
	end

endmodule

// ==== src/rxRingBuffer.sv ====
// Receive ring buffer

`timescale 1ns/1ns

module rxRingBuffer (
	input logic clock,
	input logic reset,
	input logic entryValid,
	input logic [usbBufPkg::ENTRY_W-1:0] entry,
	input logic rdReq,
	input logic [usbBufPkg::WORD_ADDR_W-1:0] rdWord,
	input logic wrStart,
	input logic wrEnd,
	input logic [usbBufPkg::INDEX_W-1:0] wrIndex,
	output logic [usbBufPkg::WORD_W-1:0] rdData,
	output logic rdDone,
	output logic [usbBufPkg::INDEX_W-1:0] rxStart,
	output logic [usbBufPkg::INDEX_W-1:0] rxEnd
);
	import usbBufPkg::*;

	logic [WORD_W-1:0] ringMem [RING_WORDS];
	logic [WORD_ADDR_W-1:0] storeWord;
	logic [1:0] storeLane;

	// entry k goes to lane k mod 4 of word k div 4
	assign storeWord = rxEnd[INDEX_W-1:2];
	assign storeLane = rxEnd[1:0];

	always_ff @(posedge clock)
	begin
		for (int lane = 0; lane < LANES; lane++)
		begin
			if (entryValid && (storeLane == 2'(lane)))
				ringMem[storeWord][lane*ENTRY_W +: ENTRY_W] <= entry;
		end
		// single port, a store wins over the host
		if (rdReq && !entryValid)
			rdData <= ringMem[rdWord];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rdDone <= 1'b0;
			rxStart <= '0;
			rxEnd <= '0;
		end
		else
		begin
			rdDone <= rdReq && !entryValid;
			if (wrStart)
				rxStart <= wrIndex;
			// wraps at 1024 with no overflow check
			if (entryValid)
				rxEnd <= rxEnd + 1'b1;
			else if (wrEnd)
				rxEnd <= wrIndex;
		end
	end

endmodule

// ==== src/usbMmioSlave.sv ====
// MMIO slave for the receive port

`timescale 1ns/1ns

module usbMmioSlave (
	input logic clock,
	input logic reset,
	input logic [usbBufPkg::MMIO_DATA_W-1:0] mmioInData,
	input logic [usbBufPkg::MMIO_ADDR_W-1:0] mmioAddr,
	input logic [usbBufPkg::MMIO_OPM_W-1:0] mmioOpm,
	output logic [usbBufPkg::MMIO_DATA_W-1:0] mmioOutData,
	output usbBufPkg::mmioOkT mmioOK,
	output logic rdReq,
	output logic [usbBufPkg::WORD_ADDR_W-1:0] rdWord,
	input logic [usbBufPkg::WORD_W-1:0] rdData,
	input logic rdDone,
	output logic wrStart,
	output logic wrEnd,
	output logic [usbBufPkg::INDEX_W-1:0] wrIndex,
	input logic [usbBufPkg::INDEX_W-1:0] rxStart,
	input logic [usbBufPkg::INDEX_W-1:0] rxEnd,
	input logic [1:0] lineState,
	input logic packetActive
);
	import usbBufPkg::*;

	logic [MMIO_DATA_W-1:0] reqData;
	logic [MMIO_ADDR_W-1:0] reqAddr;
	logic [MMIO_OPM_W-1:0] reqOpm;
	logic lowSel;
	logic bufHit;
	logic ctlHit;
	logic isRead;
	logic isWrite;
	logic [5:0] regNum;
	logic [2:0] statusWord;
	logic [MMIO_DATA_W-1:0] regValue;
	logic [MMIO_DATA_W-1:0] bufValue;
	logic [MMIO_DATA_W-1:0] dataNext;
	mmioOkT okNext;

	// request decode, on the registered copy
	assign lowSel = (reqAddr[27:16] == 12'h000);
	assign bufHit = lowSel && (reqAddr[15:13] == BUF_SEL);
	assign ctlHit = lowSel && (reqAddr[15:8] == CTL_SEL);
	assign isRead = (reqOpm[4:3] == OPM_READ);
	assign isWrite = (reqOpm[4:3] == OPM_WRITE);
	assign regNum = reqAddr[7:2];

	assign rdWord = reqAddr[10:3];
	assign wrIndex = reqData[INDEX_W-1:0];
	assign statusWord = {packetActive, lineState};

	always_comb
	begin
		case (regNum)
			REG_RX_START: regValue = MMIO_DATA_W'(rxStart);
			REG_RX_END: regValue = MMIO_DATA_W'(rxEnd);
			REG_STATUS: regValue = MMIO_DATA_W'(statusWord);
			default: regValue = '0;
		endcase
	end

	// one lane per 16-bit field, lane 0 lowest
	always_comb
	begin
		for (int lane = 0; lane < LANES; lane++)
			bufValue[lane*FIELD_W +: FIELD_W] = FIELD_W'(rdData[lane*ENTRY_W +: ENTRY_W]);
	end

	always_comb
	begin
		okNext = OK_READY;
		dataNext = mmioOutData;
		rdReq = 1'b0;
		wrStart = 1'b0;
		wrEnd = 1'b0;

		if (ctlHit && (isRead || isWrite))
		begin
			okNext = OK_OK;
			// act once, then hold the answer while the host keeps the request
			if (mmioOK != OK_OK)
			begin
				if (isRead)
					dataNext = regValue;
				else if (regNum == REG_RX_START)
					wrStart = 1'b1;
				else if (regNum == REG_RX_END)
					wrEnd = 1'b1;
			end
		end
		else if (bufHit && isRead)
		begin
			if (mmioOK == OK_OK)
				okNext = OK_OK;
			else if (rdDone)
			begin
				okNext = OK_OK;
				dataNext = bufValue;
			end
			else
			begin
				// retried until the ring has no store in the way
				okNext = OK_HOLD;
				rdReq = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOpm <= '0;
			mmioOK <= OK_READY;
		end
		else
		begin
			reqOpm <= mmioOpm;
			mmioOK <= okNext;
		end
	end

	always_ff @(posedge clock)
	begin
		reqAddr <= mmioAddr;
		reqData <= mmioInData;
		mmioOutData <= dataNext;
	end

endmodule

// ==== src/usbHostPort.sv ====
// USB receive port top level

`timescale 1ns/1ns

module usbHostPort (
	input logic clock,
	input logic reset,
	input logic dPlus,
	input logic dMinus,
	input logic [usbBufPkg::MMIO_DATA_W-1:0] mmioInData,
	input logic [usbBufPkg::MMIO_ADDR_W-1:0] mmioAddr,
	input logic [usbBufPkg::MMIO_OPM_W-1:0] mmioOpm,
	output logic [usbBufPkg::MMIO_DATA_W-1:0] mmioOutData,
	output usbBufPkg::mmioOkT mmioOK
);
	import usbBufPkg::*;

	// line to decoder
	logic [1:0] lineState;
	logic bitStrobe;

	// decoder to ring and slave
	logic entryValid;
	logic [ENTRY_W-1:0] entry;
	logic packetActive;

	// slave and ring
	logic rdReq;
	logic [WORD_ADDR_W-1:0] rdWord;
	logic [WORD_W-1:0] rdData;
	logic rdDone;
	logic wrStart;
	logic wrEnd;
	logic [INDEX_W-1:0] wrIndex;
	logic [INDEX_W-1:0] rxStart;
	logic [INDEX_W-1:0] rxEnd;

	usbLineSampler sampler (
		.clock(clock), .reset(reset), .dPlus(dPlus), .dMinus(dMinus),
		.lineState(lineState), .bitStrobe(bitStrobe)
	);

	usbRxDecoder decoder (
		.clock(clock), .reset(reset), .lineState(lineState), .bitStrobe(bitStrobe),
		.entryValid(entryValid), .entry(entry), .packetActive(packetActive)
	);

	rxRingBuffer ring (
		.clock(clock), .reset(reset), .entryValid(entryValid), .entry(entry),
		.rdReq(rdReq), .rdWord(rdWord), .wrStart(wrStart), .wrEnd(wrEnd),
		.wrIndex(wrIndex), .rdData(rdData), .rdDone(rdDone),
		.rxStart(rxStart), .rxEnd(rxEnd)
	);

	usbMmioSlave slave (
		.clock(clock), .reset(reset), .mmioInData(mmioInData), .mmioAddr(mmioAddr),
		.mmioOpm(mmioOpm), .mmioOutData(mmioOutData), .mmioOK(mmioOK),
		.rdReq(rdReq), .rdWord(rdWord), .rdData(rdData), .rdDone(rdDone),
		.wrStart(wrStart), .wrEnd(wrEnd), .wrIndex(wrIndex),
		.rxStart(rxStart), .rxEnd(rxEnd), .lineState(lineState),
		.packetActive(packetActive)
	);

endmodule

// ==== verif/usbHostPort_props.sv ====
// MMIO and ring index properties

`timescale 1ns/1ns

module usbHostPortProps (
	input logic clock,
	input logic reset,
	input logic [usbBufPkg::MMIO_OPM_W-1:0] mmioOpm,
	input logic [1:0] mmioOK,
	input logic [usbBufPkg::INDEX_W-1:0] rxEnd,
	input logic wrEnd
);
	import usbBufPkg::*;

	// code 3 is not part of the response set
	okCodeKnown: assert property (@(posedge clock) disable iff (reset)
		mmioOK != 2'd3)
		else $error("mmioOK carried the unused response code");

	// input register plus response register
	okNeedsRequest: assert property (@(posedge clock) disable iff (reset)
		(mmioOK == OK_OK) |-> ($past(mmioOpm, 2) != '0))
		else $error("OK_OK without a request two cycles earlier");

	// stores step by one, anything else must come from the host
	rxEndMotion: assert property (@(posedge clock) disable iff (reset)
		(rxEnd != $past(rxEnd)) |->
			((rxEnd == INDEX_W'($past(rxEnd) + 1'b1)) || $past(wrEnd)))
		else $error("rxEnd moved without a store or a host write");

endmodule

// ==== verif/usbHostPortTb.sv ====
// USB receive port testbench

`timescale 1ns/1ns

module usbHostPortTb;
	import usbBufPkg::*;

	typedef logic [7:0] byteQueueT[$];
	typedef logic [ENTRY_W-1:0] entryQueueT[$];

	localparam int WAIT_LIMIT = 200;
	localparam int RING_ENTRIES = 1 << INDEX_W;
	localparam logic [31:0] BUF_BASE = 32'h0000_8000;
	localparam logic [31:0] CTL_BASE = 32'h0000_E800;
	localparam logic [1:0] LINE_K = 2'b10;

	logic clock;
	logic reset;
	logic dPlus;
	logic dMinus;
	logic [MMIO_DATA_W-1:0] mmioInData;
	logic [MMIO_ADDR_W-1:0] mmioAddr;
	logic [MMIO_OPM_W-1:0] mmioOpm;
	logic [MMIO_DATA_W-1:0] mmioOutData;
	mmioOkT mmioOK;

	int checkCount;
	int errorCount;
	int timeoutCount;

	usbHostPort DUT (
		.clock(clock), .reset(reset), .dPlus(dPlus), .dMinus(dMinus),
		.mmioInData(mmioInData), .mmioAddr(mmioAddr), .mmioOpm(mmioOpm),
		.mmioOutData(mmioOutData), .mmioOK(mmioOK)
	);

	bind usbHostPort usbHostPortProps props (
		.clock(clock), .reset(reset), .mmioOpm(mmioOpm), .mmioOK(mmioOK),
		.rxEnd(rxEnd), .wrEnd(wrEnd)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// outputs are sampled just before the edge, so registered values are settled
	task automatic waitResponse(input mmioOkT code);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT)
		begin
			@(posedge clock);
			cycles++;
			seen = (mmioOK == code);
		end
		if (!seen)
		begin
			timeoutCount++;
			$display("Error: MMIO slave gave no %s response within %0d cycles",
				code.name(), WAIT_LIMIT);
		end
	endtask

	task automatic mmioAccess(input logic [1:0] op, input logic [31:0] addr,
		input logic [63:0] data, output logic [63:0] result);
		// previous answer must drain before a new request
		waitResponse(OK_READY);
		mmioOpm <= {op, 3'b000};
		mmioAddr <= addr;
		mmioInData <= data;
		waitResponse(OK_OK);
		result = mmioOutData;
		mmioOpm <= '0;
	endtask

	task automatic mmioRead(input logic [31:0] addr, output logic [63:0] result);
		mmioAccess(OPM_READ, addr, '0, result);
	endtask

	task automatic mmioWrite(input logic [31:0] addr, input logic [63:0] data);
		logic [63:0] ignored;
		mmioAccess(OPM_WRITE, addr, data, ignored);
	endtask

	function automatic logic [31:0] regAddr(input logic [5:0] num);
		return CTL_BASE | {24'd0, num, 2'b00};
	endfunction

	// line state is {D-, D+}, held for one bit time
	task automatic holdLine(input logic [1:0] state);
		dPlus <= state[0];
		dMinus <= state[1];
		repeat (BIT_CYCLES)
			@(posedge clock);
	endtask

	task automatic sendBit(input logic value, inout logic [1:0] level, inout int ones);
		if (!value)
			level = (level == LINE_J) ? LINE_K : LINE_J;
		holdLine(level);
		ones = value ? ones + 1 : 0;
		// stuffed zero after six ones
		if (ones == 6)
		begin
			level = (level == LINE_J) ? LINE_K : LINE_J;
			holdLine(level);
			ones = 0;
		end
	endtask

	task automatic sendPacket(input byteQueueT bytes);
		logic [1:0] level;
		int ones;
		level = LINE_J;
		ones = 0;
		// sync, seven zeros and a one
		for (int i = 0; i < 8; i++)
			sendBit(i == 7, level, ones);
		foreach (bytes[n])
		begin
			for (int b = 0; b < 8; b++)
				sendBit(bytes[n][b], level, ones);
		end
		holdLine(LINE_SE0);
		holdLine(LINE_SE0);
		holdLine(LINE_J);
	endtask

	// reference model, one entry per byte then the EOP marker
	function automatic entryQueueT expectedEntries(input byteQueueT bytes);
		entryQueueT entries;
		foreach (bytes[i])
			entries.push_back({1'b0, bytes[i]});
		entries.push_back(9'h100);
		return entries;
	endfunction

	function automatic byteQueueT randomBytes(input int count);
		byteQueueT bytes;
		for (int i = 0; i < count; i++)
			bytes.push_back(8'($urandom));
		return bytes;
	endfunction

	task automatic waitPacketEnd();
		logic [63:0] status;
		int polls;
		polls = 0;
		do
		begin
			mmioRead(regAddr(REG_STATUS), status);
			polls++;
		end
		while (status[2] && polls < WAIT_LIMIT);
		if (status[2])
		begin
			timeoutCount++;
			$display("Error: packet still active after %0d status polls", polls);
		end
	endtask

	task automatic compareRing(input string name, input int base, input entryQueueT expected);
		int index;
		logic [63:0] word;
		foreach (expected[i])
		begin
			index = (base + i) % RING_ENTRIES;
			mmioRead(BUF_BASE | 32'((index / 4) << 3), word);
			check($sformatf("%s entry %0d", name, i), 64'(expected[i]),
				64'(word[(index % 4) * FIELD_W +: FIELD_W]));
		end
	endtask

	task automatic receivePacket(input string name, input byteQueueT bytes);
		logic [63:0] value;
		int base;
		mmioRead(regAddr(REG_RX_END), value);
		base = int'(value[INDEX_W-1:0]);
		sendPacket(bytes);
		waitPacketEnd();
		mmioRead(regAddr(REG_RX_END), value);
		check({name, " end index"}, 64'((base + bytes.size() + 1) % RING_ENTRIES), value);
		compareRing(name, base, expectedEntries(bytes));
	endtask

	initial
	begin
		logic [63:0] value;
		logic [63:0] data;
		byteQueueT bytes;
		int base;

		void'($urandom(32'h6100_e31c));
		checkCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		reset = 1'b1;
		dPlus = 1'b0;
		dMinus = 1'b0;
		mmioInData = '0;
		mmioAddr = '0;
		mmioOpm = '0;
		repeat (4)
			@(posedge clock);
		reset <= 1'b0;

		// reset state, lines still at SE0
		@(posedge clock);
		check("response after reset", 64'(OK_READY), 64'(mmioOK));
		mmioRead(regAddr(REG_RX_START), value);
		check("start after reset", 64'd0, value);
		mmioRead(regAddr(REG_RX_END), value);
		check("end after reset", 64'd0, value);
		mmioRead(regAddr(REG_STATUS), value);
		check("status after reset", 64'd0, value);
		repeat (4)
			holdLine(LINE_J);
		mmioRead(regAddr(REG_STATUS), value);
		check("status at idle J", 64'd1, value);

		// index registers keep only ten bits
		data = {$urandom, $urandom};
		mmioWrite(regAddr(REG_RX_START), data);
		mmioRead(regAddr(REG_RX_START), value);
		check("start readback", {54'd0, data[9:0]}, value);
		data = {$urandom, $urandom};
		mmioWrite(regAddr(REG_RX_END), data);
		mmioRead(regAddr(REG_RX_END), value);
		check("end readback", {54'd0, data[9:0]}, value);
		mmioWrite(regAddr(REG_RX_START), 64'd0);
		mmioWrite(regAddr(REG_RX_END), 64'd0);

		receivePacket("random packet", randomBytes(6));

		// runs of ones force stuffed bits
		bytes = {8'hFF, 8'hFF, 8'($urandom), 8'hFF, 8'h7E};
		receivePacket("stuffed packet", bytes);

		// no sync, then SE0 on its own
		mmioRead(regAddr(REG_RX_END), value);
		base = int'(value[INDEX_W-1:0]);
		repeat (3)
			holdLine(LINE_J);
		holdLine(LINE_K);
		holdLine(LINE_J);
		holdLine(LINE_K);
		repeat (3)
			holdLine(LINE_J);
		holdLine(LINE_SE0);
		holdLine(LINE_SE0);
		repeat (2)
			holdLine(LINE_J);
		mmioRead(regAddr(REG_RX_END), value);
		check("stray SE0 end index", 64'(base), value);

		// entries 1020 to 1023 land in word 255, the rest wrap to word 0
		mmioWrite(regAddr(REG_RX_END), 64'd1020);
		receivePacket("wrap packet", randomBytes(5));

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
			checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== sim.f ====
src/usbBufPkg.sv
src/usbLineSampler.sv
src/usbRxDecoder.sv
src/rxRingBuffer.sv
src/usbMmioSlave.sv
src/usbHostPort.sv
verif/usbHostPort_props.sv
verif/usbHostPortTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the USB receive port testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module usbHostPortTb -f sim.f -o usbHostPortSim > build.log 2>&1 \
	&& ./obj_dir/usbHostPortSim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "Test completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
